// File: logic/log_pack_params.svh
`ifndef LOG_PACK_PARAMS_SVH
`define LOG_PACK_PARAMS_SVH

////////////////////////////////////////
// log channel widths in bits
////////////////////////////////////////
`define LP_CH0_W 8
`define LP_CH1_W 16
`define LP_CH2_W 8
`define LP_CH3_W 32

`define LP_NUM_CH 4

// sum of all channel widths
`define LP_FULL_W 64

// record length field, holds 0 to LP_FULL_W
`define LP_LEN_W 7

// output beat width
`define LP_BEAT_W 16

`endif

// File: logic/log_pack_pkg.sv
`include "log_pack_params.svh"

package log_pack_pkg;

  ////////////////////////////////////////
  // framer states
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    FRAME_IDLE,
    FRAME_HEADER,
    FRAME_DATA
  } frame_state_e;

  // one beat on the output stream
  typedef logic [`LP_BEAT_W-1:0] log_beat_t;

  // header beat, mask sits in the low bits
  typedef struct packed {
    logic [`LP_BEAT_W-`LP_LEN_W-`LP_NUM_CH-1:0] rsvd;
    logic [`LP_LEN_W-1:0]                       len;
    logic [`LP_NUM_CH-1:0]                      mask;
  } log_header_t;

endpackage

// File: logic/packed_log_if.sv
`timescale 1ns/1ps

interface packed_log_if #(
  parameter int FULL_WIDTH = 8,
  parameter int MASK_W     = 1
);
  // wide enough for a length of 0 to FULL_WIDTH
  localparam int LEN_W = $clog2(FULL_WIDTH + 1);

  logic                  valid;
  // compacted bits at the bottom, zeros above len
  logic [FULL_WIDTH-1:0] data;
  logic [LEN_W-1:0]      len;
  logic [MASK_W-1:0]     mask;
  logic                  ready;

  modport prod (output valid, data, len, mask, input ready);
  modport cons (input valid, data, len, mask, output ready);

endinterface

// File: logic/skid_buf.sv
`timescale 1ns/1ps

module skid_buf #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             in_ready,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data,
  input  logic             out_ready
);

  logic             main_valid;
  logic             skid_valid;
  logic [WIDTH-1:0] main_data;
  logic [WIDTH-1:0] skid_data;
  logic             main_free;
  logic             in_fire;

  // main entry can take a new value this cycle
  assign main_free = out_ready || !main_valid;
  assign in_fire   = in_valid && in_ready;

  // only the skid entry holds back the input, so in_ready is a flop
  assign in_ready  = !skid_valid;
  assign out_valid = main_valid;
  assign out_data  = main_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      if (skid_valid) begin
        main_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        main_valid <= in_valid;
      end
    end else if (in_fire) begin
      // downstream stalled, park the incoming value
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      main_data <= skid_valid ? skid_data : in_data;
    end
    if (!main_free && in_fire) begin
      skid_data <= in_data;
    end
  end

endmodule

// File: logic/log_merge2.sv
`timescale 1ns/1ps

module log_merge2 #(
  parameter int WIDTH_A = 8,
  parameter int WIDTH_B = 8
) (
  input logic        clk,
  input logic        rst,
  packed_log_if.cons a,
  packed_log_if.cons b,
  packed_log_if.prod y
);

  localparam int WIDTH_Y = WIDTH_A + WIDTH_B;
  localparam int LEN_Y_W = $clog2(WIDTH_Y + 1);
  localparam int MASK_Y_W = y.MASK_W;
  localparam int PAY_W = WIDTH_Y + LEN_Y_W + MASK_Y_W;

  logic [WIDTH_A-1:0]  keep_a;
  logic [WIDTH_B-1:0]  keep_b;
  logic [WIDTH_Y-1:0]  data_c;
  logic [LEN_Y_W-1:0]  len_c;
  logic [MASK_Y_W-1:0] mask_c;
  logic                sb_in_ready;

  ////////////////////////////////////////
  // compaction
  ////////////////////////////////////////

  // clear bits above each len so absent channels leave nothing behind
  assign keep_a = ~({WIDTH_A{1'b1}} << a.len);
  assign keep_b = ~({WIDTH_B{1'b1}} << b.len);

  // b lands right on top of the valid bits of a
  assign data_c = WIDTH_Y'(a.data & keep_a) | (WIDTH_Y'(b.data & keep_b) << a.len);
  assign len_c  = LEN_Y_W'(a.len) + LEN_Y_W'(b.len);
  assign mask_c = {b.mask, a.mask};

  // a and b advance in lockstep, one ready serves both
  assign a.ready = sb_in_ready;
  assign b.ready = sb_in_ready;

  skid_buf #(
    .WIDTH(PAY_W)
  ) u_sbuf (
    .clk      (clk),
    .rst      (rst),
    .in_valid (a.valid),
    .in_data  ({data_c, len_c, mask_c}),
    .in_ready (sb_in_ready),
    .out_valid(y.valid),
    .out_data ({y.data, y.len, y.mask}),
    .out_ready(y.ready)
  );

endmodule

// File: logic/beat_counter.sv
`timescale 1ns/1ps
`include "log_pack_params.svh"

module beat_counter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  logic [`LP_LEN_W-1:0] len,
  input  logic                 step,
  output logic                 last
);

  localparam int SHIFT = $clog2(`LP_BEAT_W);
  localparam int CNT_W = `LP_LEN_W - SHIFT + 1;

  logic [`LP_LEN_W:0] len_rnd;
  logic [CNT_W-1:0]   count;

  // round up to whole beats
  assign len_rnd = {1'b0, len} + (`LP_LEN_W + 1)'(`LP_BEAT_W - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= len_rnd[`LP_LEN_W:SHIFT];
    end else if (step && count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign last = (count == CNT_W'(1));

endmodule

// File: logic/frame_fsm.sv
`timescale 1ns/1ps
`include "log_pack_params.svh"

module frame_fsm (
  input  logic                    clk,
  input  logic                    rst,
  packed_log_if.cons              rec,
  output logic                    out_valid,
  input  logic                    out_ready,
  output log_pack_pkg::log_beat_t out_data,
  output logic                    out_last
);

  log_pack_pkg::frame_state_e  state;
  log_pack_pkg::log_header_t   hdr_q;
  logic [`LP_FULL_W-1:0]       word_q;
  logic                        rec_fire;
  logic                        start;
  logic                        data_step;
  logic                        last;

  assign rec.ready = (state == log_pack_pkg::FRAME_IDLE);
  assign rec_fire  = rec.valid && rec.ready;
  // empty records are consumed but never framed
  assign start     = rec_fire && (|rec.mask);
  assign data_step = (state == log_pack_pkg::FRAME_DATA) && out_ready;

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= log_pack_pkg::FRAME_IDLE;
    end else begin
      unique case (state)
        log_pack_pkg::FRAME_IDLE:   if (start) state <= log_pack_pkg::FRAME_HEADER;
        log_pack_pkg::FRAME_HEADER: if (out_ready) state <= log_pack_pkg::FRAME_DATA;
        log_pack_pkg::FRAME_DATA:   if (out_ready && last) state <= log_pack_pkg::FRAME_IDLE;
        default:                    state <= log_pack_pkg::FRAME_IDLE;
      endcase
    end
  end

  // latch the record, then walk it out from the low end
  always_ff @(posedge clk) begin
    if (rec_fire) begin
      word_q     <= rec.data;
      hdr_q.rsvd <= '0;
      hdr_q.len  <= rec.len;
      hdr_q.mask <= rec.mask;
    end else if (data_step) begin
      word_q <= word_q >> `LP_BEAT_W;
    end
  end

  beat_counter u_beats (
    .clk (clk),
    .rst (rst),
    .load(start),
    .len (rec.len),
    .step(data_step),
    .last(last)
  );

  always_comb begin
    out_valid = (state != log_pack_pkg::FRAME_IDLE);
    out_last  = (state == log_pack_pkg::FRAME_DATA) && last;
    unique case (state)
      log_pack_pkg::FRAME_HEADER: out_data = log_pack_pkg::log_beat_t'(hdr_q);
      log_pack_pkg::FRAME_DATA:   out_data = word_q[`LP_BEAT_W-1:0];
      default:                    out_data = '0;
    endcase
  end

endmodule

// File: logic/log_packer_top.sv
`timescale 1ns/1ps
`include "log_pack_params.svh"

module log_packer_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  logic [`LP_NUM_CH-1:0]   in_mask,
  input  logic [`LP_CH0_W-1:0]    ch0_data,
  input  logic [`LP_CH1_W-1:0]    ch1_data,
  input  logic [`LP_CH2_W-1:0]    ch2_data,
  input  logic [`LP_CH3_W-1:0]    ch3_data,
  output logic                    out_valid,
  input  logic                    out_ready,
  output log_pack_pkg::log_beat_t out_data,
  output logic                    out_last
);

  packed_log_if #(.FULL_WIDTH(`LP_CH0_W), .MASK_W(1)) leaf0 ();
  packed_log_if #(.FULL_WIDTH(`LP_CH1_W), .MASK_W(1)) leaf1 ();
  packed_log_if #(.FULL_WIDTH(`LP_CH2_W), .MASK_W(1)) leaf2 ();
  packed_log_if #(.FULL_WIDTH(`LP_CH3_W), .MASK_W(1)) leaf3 ();
  packed_log_if #(.FULL_WIDTH(`LP_CH0_W + `LP_CH1_W), .MASK_W(2)) m01_bus ();
  packed_log_if #(.FULL_WIDTH(`LP_CH2_W + `LP_CH3_W), .MASK_W(2)) m23_bus ();
  packed_log_if #(.FULL_WIDTH(`LP_FULL_W), .MASK_W(`LP_NUM_CH)) root_bus ();

  ////////////////////////////////////////
  // leaf extraction
  ////////////////////////////////////////
  assign leaf0.valid = in_valid;
  assign leaf0.data  = ch0_data;
  assign leaf0.len   = in_mask[0] ? leaf0.LEN_W'(`LP_CH0_W) : '0;
  assign leaf0.mask  = in_mask[0];

  assign leaf1.valid = in_valid;
  assign leaf1.data  = ch1_data;
  assign leaf1.len   = in_mask[1] ? leaf1.LEN_W'(`LP_CH1_W) : '0;
  assign leaf1.mask  = in_mask[1];

  assign leaf2.valid = in_valid;
  assign leaf2.data  = ch2_data;
  assign leaf2.len   = in_mask[2] ? leaf2.LEN_W'(`LP_CH2_W) : '0;
  assign leaf2.mask  = in_mask[2];

  assign leaf3.valid = in_valid;
  assign leaf3.data  = ch3_data;
  assign leaf3.len   = in_mask[3] ? leaf3.LEN_W'(`LP_CH3_W) : '0;
  assign leaf3.mask  = in_mask[3];

  // m23 sees the same accepts and stalls as m01
  assign in_ready = leaf0.ready;

  ////////////////////////////////////////
  // merge tree, 2 + 2 leaves
  ////////////////////////////////////////
  log_merge2 #(.WIDTH_A(`LP_CH0_W), .WIDTH_B(`LP_CH1_W)) u_m01 (
    .clk(clk), .rst(rst), .a(leaf0), .b(leaf1), .y(m01_bus)
  );

  log_merge2 #(.WIDTH_A(`LP_CH2_W), .WIDTH_B(`LP_CH3_W)) u_m23 (
    .clk(clk), .rst(rst), .a(leaf2), .b(leaf3), .y(m23_bus)
  );

  log_merge2 #(
    .WIDTH_A(`LP_CH0_W + `LP_CH1_W),
    .WIDTH_B(`LP_CH2_W + `LP_CH3_W)
  ) u_mroot (
    .clk(clk), .rst(rst), .a(m01_bus), .b(m23_bus), .y(root_bus)
  );

  frame_fsm u_framer (
    .clk      (clk),
    .rst      (rst),
    .rec      (root_bus),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .out_last (out_last)
  );

endmodule

// File: tests/log_packer_assertions.sv
`timescale 1ns/1ps

module log_packer_assertions (
  input logic                       clk,
  input logic                       rst,
  input logic                       out_valid,
  input logic                       out_ready,
  input log_pack_pkg::log_beat_t    out_data,
  input logic                       out_last,
  input log_pack_pkg::frame_state_e state
);

  // number of failed assertions
  int fail_count;

  // output comes up idle after reset
  a_reset_idle: assert property (@(posedge clk)
    rst |=> (!out_valid && state == log_pack_pkg::FRAME_IDLE))
    else begin
      $error("framer not idle in the cycle after reset");
      fail_count++;
    end

  // a stalled beat holds its contents
  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)))
    else begin
      $error("output beat changed while stalled");
      fail_count++;
    end

  a_last_valid: assert property (@(posedge clk) disable iff (rst) out_last |-> out_valid)
    else begin
      $error("out_last high without out_valid");
      fail_count++;
    end

endmodule

bind log_packer_top log_packer_assertions u_checks (
  .clk      (clk),
  .rst      (rst),
  .out_valid(out_valid),
  .out_ready(out_ready),
  .out_data (out_data),
  .out_last (out_last),
  .state    (u_framer.state)
);

// File: tests/log_packer_tb.sv
`timescale 1ns/1ps
`include "log_pack_params.svh"

module log_packer_tb;

  localparam int TIMEOUT = 400;
  localparam int MAX_BEATS = `LP_FULL_W / `LP_BEAT_W;
  localparam logic [31:0] SEED = 32'h82830783;

  logic                    clk;
  logic                    rst;
  logic                    in_valid;
  logic                    in_ready;
  logic [`LP_NUM_CH-1:0]   in_mask;
  logic [`LP_CH0_W-1:0]    ch0_data;
  logic [`LP_CH1_W-1:0]    ch1_data;
  logic [`LP_CH2_W-1:0]    ch2_data;
  logic [`LP_CH3_W-1:0]    ch3_data;
  logic                    out_valid;
  logic                    out_ready;
  log_pack_pkg::log_beat_t out_data;
  logic                    out_last;

  // expected beat entry is {is_header, is_last, beat}
  logic [`LP_BEAT_W+1:0] exp_q[$];
  logic [31:0]           data_lfsr;
  logic [31:0]           stall_lfsr;
  logic                  stall_en;
  int                    cyc;
  int                    errors;
  int                    frames_seen;
  int                    accept_cyc;
  int                    hdr_cyc;

  log_packer_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_mask  (in_mask),
    .ch0_data (ch0_data),
    .ch1_data (ch1_data),
    .ch2_data (ch2_data),
    .ch3_data (ch3_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .out_last (out_last)
  );

  always #50 clk = ~clk;

  // edge count, cyc equals k right after edge k
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////
  // random bits and reference model
  ////////////////////////////////////////

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_step(st);
      v = {v[30:0], st[0]};
    end
  endtask

  // returns the data beat count, 0 when nothing is framed
  function automatic int pack_record(
    input  logic [`LP_NUM_CH-1:0]     mask,
    input  logic [`LP_CH0_W-1:0]      c0,
    input  logic [`LP_CH1_W-1:0]      c1,
    input  logic [`LP_CH2_W-1:0]      c2,
    input  logic [`LP_CH3_W-1:0]      c3,
    output log_pack_pkg::log_header_t hdr,
    output log_pack_pkg::log_beat_t   beats[MAX_BEATS]
  );
    logic [`LP_FULL_W-1:0] word;
    int pos;
    word = '0;
    pos = 0;
    if (mask[0]) begin
      word |= `LP_FULL_W'(c0) << pos;
      pos += `LP_CH0_W;
    end
    if (mask[1]) begin
      word |= `LP_FULL_W'(c1) << pos;
      pos += `LP_CH1_W;
    end
    if (mask[2]) begin
      word |= `LP_FULL_W'(c2) << pos;
      pos += `LP_CH2_W;
    end
    if (mask[3]) begin
      word |= `LP_FULL_W'(c3) << pos;
      pos += `LP_CH3_W;
    end
    hdr.rsvd = '0;
    hdr.len  = `LP_LEN_W'(pos);
    hdr.mask = mask;
    for (int i = 0; i < MAX_BEATS; i++) begin
      beats[i] = word[i*`LP_BEAT_W +: `LP_BEAT_W];
    end
    return (pos + `LP_BEAT_W - 1) / `LP_BEAT_W;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_header(input log_pack_pkg::log_header_t exp,
                              input log_pack_pkg::log_header_t act);
    if (act !== exp) begin
      $display("[FAIL] out_data header expected %h got %h", exp, act);
      errors++;
    end
  endtask

  task automatic check_beat(input log_pack_pkg::log_beat_t exp,
                            input log_pack_pkg::log_beat_t act);
    if (act !== exp) begin
      $display("[FAIL] out_data beat expected %h got %h", exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string sig, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h got %h", sig, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("[FAIL] %s expected %h got %h", what, exp, act);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("timeout while waiting for %s", what);
    $display("TEST FAILED");
    $finish;
  endtask

  ////////////////////////////////////////
  // driver, monitor, output stalls
  ////////////////////////////////////////
  task automatic send_record(input logic [`LP_NUM_CH-1:0] mask,
                             input logic [`LP_CH0_W-1:0] c0,
                             input logic [`LP_CH1_W-1:0] c1,
                             input logic [`LP_CH2_W-1:0] c2,
                             input logic [`LP_CH3_W-1:0] c3);
    log_pack_pkg::log_header_t hdr;
    log_pack_pkg::log_beat_t   beats[MAX_BEATS];
    int n;
    int waited;
    n = pack_record(mask, c0, c1, c2, c3, hdr, beats);
    in_valid = 1'b1;
    in_mask  = mask;
    ch0_data = c0;
    ch1_data = c1;
    ch2_data = c2;
    ch3_data = c3;
    waited = 0;
    while (!in_ready) begin
      @(posedge clk);
      #10;
      waited++;
      if (waited > TIMEOUT) abort_run("in_ready to accept a record");
    end
    @(posedge clk);
    #10;
    accept_cyc = cyc;
    if (n > 0) begin
      exp_q.push_back({1'b1, 1'b0, log_pack_pkg::log_beat_t'(hdr)});
      for (int i = 0; i < n; i++) begin
        exp_q.push_back({1'b0, i == n - 1, beats[i]});
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || out_valid) begin
      @(posedge clk);
      #10;
      waited++;
      if (waited > TIMEOUT) abort_run("the expected beat queue to drain");
    end
  endtask

  task automatic end_test(input int num, input string name, input int base_err);
    $display("test %0d %s: %0d errors", num, name, errors - base_err);
  endtask

  // a beat seen at the falling edge transfers on the next rising edge
  always @(negedge clk) begin : monitor
    logic [`LP_BEAT_W+1:0] e;
    if (!rst && out_valid && out_ready) begin
      // frames are counted on the DUT's own out_last
      if (out_last) frames_seen++;
      if (exp_q.size() == 0) begin
        $display("output beat %h arrived with nothing expected", out_data);
        errors++;
      end else begin
        e = exp_q.pop_front();
        if (e[`LP_BEAT_W+1]) begin
          check_header(log_pack_pkg::log_header_t'(e[`LP_BEAT_W-1:0]),
                       log_pack_pkg::log_header_t'(out_data));
          hdr_cyc = cyc + 1;
        end else begin
          check_beat(e[`LP_BEAT_W-1:0], out_data);
        end
        check_bit("out_last", e[`LP_BEAT_W], out_last);
      end
    end
  end

  always @(posedge clk) begin : ready_drive
    logic [31:0] r;
    #10;
    if (stall_en) begin
      take_bits(stall_lfsr, 2, r);
      out_ready = (r[1:0] != 2'b00);
    end else begin
      out_ready = 1'b1;
    end
  end

  initial begin
    logic [31:0] rnd_m;
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    int base_err;
    int base_frames;
    int nonzero;
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_mask = '0;
    ch0_data = '0;
    ch1_data = '0;
    ch2_data = '0;
    ch3_data = '0;
    out_ready = 1'b1;
    stall_en = 1'b0;
    data_lfsr = SEED;
    stall_lfsr = SEED;
    cyc = 0;
    errors = 0;
    frames_seen = 0;
    repeat (5) @(posedge clk);
    #10;
    rst = 1'b0;

    base_err = errors;
    check_bit("out_valid", 1'b0, out_valid);
    check_bit("in_ready", 1'b1, in_ready);
    end_test(1, "reset state", base_err);

    base_err = errors;
    send_record(4'hF, 8'hA1, 16'hB2C3, 8'hD4, 32'hE5F60718);
    wait_drained();
    check_count("header latency", 3, hdr_cyc - accept_cyc);
    end_test(2, "full record", base_err);

    base_err = errors;
    send_record(4'b1010, 8'h11, 16'h2233, 8'h44, 32'h55667788);
    send_record(4'b0100, 8'h99, 16'hAABB, 8'hCC, 32'hDDEEFF00);
    send_record(4'b1001, 8'h5A, 16'hC3C3, 8'h0F, 32'h12345678);
    send_record(4'b0110, 8'h01, 16'h8002, 8'h7E, 32'hCAFE0001);
    wait_drained();
    end_test(3, "partial masks", base_err);

    base_err = errors;
    base_frames = frames_seen;
    send_record(4'b0000, 8'hFF, 16'hFFFF, 8'hFF, 32'hFFFFFFFF);
    send_record(4'b0011, 8'h3C, 16'h4D5E, 8'h00, 32'h00000000);
    wait_drained();
    check_count("frame count", 1, frames_seen - base_frames);
    end_test(4, "empty record", base_err);

    base_err = errors;
    base_frames = frames_seen;
    nonzero = 0;
    stall_en = 1'b1;
    for (int r = 0; r < 200; r++) begin
      take_bits(data_lfsr, `LP_NUM_CH, rnd_m);
      take_bits(data_lfsr, 32, rnd_a);
      take_bits(data_lfsr, 32, rnd_b);
      if (rnd_m[3:0] != 4'h0) nonzero++;
      send_record(rnd_m[3:0], rnd_b[7:0], rnd_b[23:8], rnd_b[31:24], rnd_a);
    end
    stall_en = 1'b0;
    wait_drained();
    check_count("frame count", nonzero, frames_seen - base_frames);
    end_test(5, "random stalls", base_err);

    // failed bound assertions count as errors
    errors += u_dut.u_checks.fail_count;
    $display("summary: 5 tests, %0d frames, %0d errors", frames_seen, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+logic
logic/log_pack_pkg.sv
logic/packed_log_if.sv
logic/skid_buf.sv
logic/log_merge2.sv
logic/beat_counter.sv
logic/frame_fsm.sv
logic/log_packer_top.sv
tests/log_packer_assertions.sv
tests/log_packer_tb.sv

// File: Bender.yml
package:
  name: log_packer

sources:
  - include_dirs:
      - logic
    files:
      - logic/log_pack_pkg.sv
      - logic/packed_log_if.sv
      - logic/skid_buf.sv
      - logic/log_merge2.sv
      - logic/beat_counter.sv
      - logic/frame_fsm.sv
      - logic/log_packer_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/log_packer_assertions.sv
      - tests/log_packer_tb.sv
